/* Bender.yml */
package:
  name: rv_core_lite

sources:
  - hw/rv_pkg.sv
  - hw/rv_rf_if.sv
  - hw/rv_stage_buf.sv
  - hw/rv_id.sv
  - hw/rv_exec.sv
  - hw/rv_result.sv
  - hw/rv_core_lite.sv
  - target: test
    files:
      - dv/rv_clk_gen.sv
      - dv/rv_core_lite_tb.sv

/* dv/rv_clk_gen.sv */
`timescale 1ns/1ps

module rv_clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic arst_n_o
);

  // free running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset leaves on a falling edge, away from the sampling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

/* dv/rv_core_lite_tb.sv */
`timescale 1ns/1ps

module rv_core_lite_tb;

  localparam int CLK_PERIOD = 100;
  localparam int N_RAND     = 60;
  // directed instructions in the main sequence
  localparam int N_DIRECTED = 37;
  localparam int N_INSTR    = N_DIRECTED + N_RAND;
  localparam int K_WB       = 0;
  localparam int K_ILL      = 1;
  localparam int K_ERR      = 2;
  localparam logic [6:0] OPC_LD  = 7'b0000011;
  localparam logic [6:0] OPC_OPI = 7'b0010011;
  localparam logic [6:0] OPC_OPR = 7'b0110011;
  localparam logic [6:0] OPC_LU  = 7'b0110111;

  logic        clk;
  logic        arst_n;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic        instr_ready_o;
  logic [31:0] araddr_o;
  logic [2:0]  arprot_o;
  logic        arvalid_o;
  logic        arready_i;
  logic [31:0] rdata_i;
  logic [1:0]  rresp_i;
  logic        rvalid_i;
  logic        rready_o;
  logic        wb_valid_o;
  logic [4:0]  wb_rd_o;
  logic [31:0] wb_data_o;
  logic        illegal_o;
  logic        load_err_o;

  integer      seed = 32'h95c1_6aaf;
  int          errors = 0;
  int          cyc = 0;
  logic [31:0] mregs [32];
  logic        r_wait;

  // expected events in acceptance order
  int          q_kind [$];
  logic [4:0]  q_rd [$];
  logic [31:0] q_data [$];
  int          q_due [$];
  logic        head_vld;
  int          head_kind;
  logic [4:0]  head_rd;
  logic [31:0] head_data;
  int          head_due;

  rv_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(3)) u_clk (
    .clk_o   (clk),
    .arst_n_o(arst_n)
  );

  rv_core_lite u_dut (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .instr_valid_i(instr_valid_i),
    .instr_i      (instr_i),
    .instr_ready_o(instr_ready_o),
    .araddr_o     (araddr_o),
    .arprot_o     (arprot_o),
    .arvalid_o    (arvalid_o),
    .arready_i    (arready_i),
    .rdata_i      (rdata_i),
    .rresp_i      (rresp_i),
    .rvalid_i     (rvalid_i),
    .rready_o     (rready_o),
    .wb_valid_o   (wb_valid_o),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o),
    .illegal_o    (illegal_o),
    .load_err_o   (load_err_o)
  );

  //////////////////////////////////////////////////
  // encoders
  //////////////////////////////////////////////////

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OPR};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_LU};
  endfunction

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // rv32i arithmetic with alt selecting sub or sra
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic apply_model(input logic [31:0] ins);
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] immi;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] lane_b;
    logic [31:0] lane_h;
    int          kind;
    bit          legal;
    bit          ld;
    opc   = ins[6:0];
    f3    = ins[14:12];
    f7    = ins[31:25];
    rd    = ins[11:7];
    a     = mregs[ins[19:15]];
    immi  = {{20{ins[31]}}, ins[31:20]};
    kind  = K_WB;
    legal = 1'b1;
    ld    = 1'b0;
    res   = '0;
    case (opc)
      OPC_LU: res = {ins[31:12], 12'b0};
      OPC_OPI: begin
        if (f3 == 3'd1) legal = (f7 == 7'h00);
        if (f3 == 3'd5) legal = (f7 == 7'h00) || (f7 == 7'h20);
        res = alu_ref(f3, (f3 == 3'd5) && f7[5], a, immi);
      end
      OPC_OPR: begin
        legal = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
        res   = alu_ref(f3, f7[5], a, mregs[ins[24:20]]);
      end
      OPC_LD: begin
        ld     = 1'b1;
        legal  = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        addr   = a + immi;
        // responder word for this address
        word   = {addr[31:2], 2'b00} ^ 32'hA5A5_5A5A;
        lane_b = word >> {addr[1:0], 3'b000};
        lane_h = word >> {addr[1], 4'b0000};
        case (f3)
          3'd0:    res = {{24{lane_b[7]}}, lane_b[7:0]};
          3'd1:    res = {{16{lane_h[15]}}, lane_h[15:0]};
          3'd4:    res = {24'b0, lane_b[7:0]};
          3'd5:    res = {16'b0, lane_h[15:0]};
          default: res = word;
        endcase
        if (addr >= 32'hF000_0000) kind = K_ERR;
      end
      default: legal = 1'b0;
    endcase
    if (!legal) kind = K_ILL;
    if (kind == K_WB && rd != 5'd0) mregs[rd] = res;
    if (rd == 5'd0) res = '0;
    q_kind.push_back(kind);
    q_rd.push_back(rd);
    q_data.push_back(res);
    // loads have no fixed latency
    q_due.push_back((ld && legal) ? 0 : cyc + 2);
  endtask

  // counts edges and keeps the expected queue in step
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (arst_n) begin
      if ((wb_valid_o || illegal_o || load_err_o) && q_kind.size() > 0) begin
        void'(q_kind.pop_front());
        void'(q_rd.pop_front());
        void'(q_data.pop_front());
        void'(q_due.pop_front());
      end
      if (instr_valid_i && instr_ready_o) apply_model(instr_i);
    end
    head_vld  = (q_kind.size() > 0);
    head_kind = head_vld ? q_kind[0] : -1;
    head_rd   = head_vld ? q_rd[0] : '0;
    head_data = head_vld ? q_data[0] : '0;
    head_due  = head_vld ? q_due[0] : 0;
  end

  // read data is awaited from the ar handshake until the r handshake
  always @(posedge clk) begin
    if (!arst_n) begin
      r_wait = 1'b0;
    end else if (arvalid_o && arready_i) begin
      r_wait = 1'b1;
    end else if (rvalid_i && rready_o) begin
      r_wait = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  a_wb_match: assert property (@(posedge clk) disable iff (!arst_n)
    wb_valid_o |-> head_vld && head_kind == K_WB && wb_rd_o == head_rd &&
                   wb_data_o == head_data && (head_due == 0 || head_due == cyc + 1))
    else begin
      errors++;
      $display("** Error at %0t ns: writeback rd %0d data %h, expected rd %0d data %h",
               $time, wb_rd_o, wb_data_o, head_rd, head_data);
    end

  a_illegal: assert property (@(posedge clk) disable iff (!arst_n)
    illegal_o |-> head_vld && head_kind == K_ILL && head_due == cyc + 1)
    else begin
      errors++;
      $display("** Error at %0t ns: illegal pulse where kind %0d was expected",
               $time, head_kind);
    end

  a_load_err: assert property (@(posedge clk) disable iff (!arst_n)
    load_err_o |-> head_vld && head_kind == K_ERR)
    else begin
      errors++;
      $display("** Error at %0t ns: load error pulse where kind %0d was expected",
               $time, head_kind);
    end

  // fixed two edge latency outside loads
  a_latency: assert property (@(posedge clk) disable iff (!arst_n)
    head_vld && head_due != 0 && head_due == cyc + 1 |-> wb_valid_o || illegal_o)
    else begin
      errors++;
      $display("** Error at %0t ns: result missing two edges after acceptance", $time);
    end

  a_one_event: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0({wb_valid_o, illegal_o, load_err_o}))
    else begin
      errors++;
      $display("** Error at %0t ns: more than one result event in a cycle", $time);
    end

  a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
    arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
    else begin
      errors++;
      $display("** Error at %0t ns: read request dropped or moved before arready", $time);
    end

  a_ar_form: assert property (@(posedge clk) disable iff (!arst_n)
    arvalid_o |-> arprot_o == 3'b000 && araddr_o[1:0] == 2'b00)
    else begin
      errors++;
      $display("** Error at %0t ns: araddr %h arprot %b", $time, araddr_o, arprot_o);
    end

  a_rready_window: assert property (@(posedge clk) disable iff (!arst_n)
    rready_o |-> r_wait)
    else begin
      errors++;
      $display("** Error at %0t ns: rready high with no read response awaited", $time);
    end

  //////////////////////////////////////////////////
  // memory responder
  //////////////////////////////////////////////////

  initial begin : respond
    int          dly;
    logic [31:0] addr;
    bit          hs;
    arready_i = 1'b0;
    rvalid_i  = 1'b0;
    rdata_i   = '0;
    rresp_i   = '0;
    forever begin
      @(negedge clk);
      if (arvalid_o) begin
        dly = $unsigned($random(seed)) % 4;
        repeat (dly) @(negedge clk);
        addr      = araddr_o;
        arready_i = 1'b1;
        @(negedge clk);
        arready_i = 1'b0;
        dly = $unsigned($random(seed)) % 4;
        repeat (dly) @(negedge clk);
        rdata_i  = addr ^ 32'hA5A5_5A5A;
        // slverr for the top of the map
        rresp_i  = (addr >= 32'hF000_0000) ? 2'b10 : 2'b00;
        rvalid_i = 1'b1;
        do begin
          hs = rready_o;
          @(negedge clk);
        end while (!hs);
        rvalid_i = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // valid stays high and the next item follows the accepting edge
  task automatic issue(input logic [31:0] ins);
    instr_valid_i = 1'b1;
    instr_i       = ins;
    do @(posedge clk); while (!(instr_valid_i && instr_ready_o));
    @(negedge clk);
  endtask

  task automatic issue_random();
    int          sel;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [2:0]  ld_f3 [5];
    ld_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    sel = $unsigned($random(seed)) % 4;
    rd  = 5'd1 + 5'($unsigned($random(seed)) % 9);
    rs1 = 5'($unsigned($random(seed)) % 10);
    f3  = 3'($random(seed));
    imm = 12'($random(seed));
    case (sel)
      0: issue(enc_u(20'($random(seed)), rd));
      1: begin
        if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
        if (f3 == 3'd5) imm = {imm[11] ? 7'h20 : 7'h00, imm[4:0]};
        issue(enc_i(imm, rs1, f3, rd, OPC_OPI));
      end
      2: issue(enc_r(((f3 == 3'd0 || f3 == 3'd5) && imm[0]) ? 7'h20 : 7'h00,
                     5'($unsigned($random(seed)) % 10), rs1, f3, rd));
      default: begin
        f3  = ld_f3[$unsigned($random(seed)) % 5];
        imm = {6'b0, imm[5:0]};
        if (f3 == 3'd2) imm[1:0] = 2'b00;
        if (f3 == 3'd1 || f3 == 3'd5) imm[0] = 1'b0;
        issue(enc_i(imm, 5'd10, f3, rd, OPC_LD));
      end
    endcase
  endtask

  initial begin
    instr_valid_i = 1'b0;
    instr_i       = '0;
    foreach (mregs[i]) mregs[i] = '0;
    @(posedge arst_n);
    @(negedge clk);
    // register values and alu forms
    issue(enc_u(20'h80000, 5'd1));
    issue(enc_i(12'h7ff, 5'd0, 3'd0, 5'd2, OPC_OPI));
    issue(enc_i(12'hffd, 5'd0, 3'd0, 5'd3, OPC_OPI));
    issue(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd4));
    issue(enc_r(7'h00, 5'd3, 5'd2, 3'd2, 5'd5));
    issue(enc_r(7'h00, 5'd3, 5'd2, 3'd3, 5'd6));
    issue(enc_i(12'h000, 5'd3, 3'd2, 5'd7, OPC_OPI));
    issue(enc_i(12'h004, 5'd3, 3'd1, 5'd7, OPC_OPI));
    issue(enc_i(12'h003, 5'd1, 3'd5, 5'd8, OPC_OPI));
    issue(enc_i(12'h403, 5'd1, 3'd5, 5'd9, OPC_OPI));
    issue(enc_r(7'h00, 5'd2, 5'd3, 3'd1, 5'd7));
    issue(enc_r(7'h00, 5'd2, 5'd1, 3'd5, 5'd8));
    issue(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd9));
    // dependent chain
    issue(enc_i(12'h007, 5'd5, 3'd0, 5'd5, OPC_OPI));
    issue(enc_i(12'h007, 5'd5, 3'd0, 5'd5, OPC_OPI));
    issue(enc_r(7'h00, 5'd4, 5'd5, 3'd4, 5'd6));
    issue(enc_r(7'h00, 5'd6, 5'd6, 3'd6, 5'd6));
    issue(enc_r(7'h00, 5'd5, 5'd6, 3'd7, 5'd7));
    // all load widths then a use of the loaded values
    issue(enc_u(20'h12345, 5'd10));
    issue(enc_i(12'h001, 5'd10, 3'd0, 5'd1, OPC_LD));
    issue(enc_i(12'h002, 5'd10, 3'd1, 5'd2, OPC_LD));
    issue(enc_i(12'h004, 5'd10, 3'd2, 5'd3, OPC_LD));
    issue(enc_i(12'h003, 5'd10, 3'd4, 5'd4, OPC_LD));
    issue(enc_i(12'h006, 5'd10, 3'd5, 5'd5, OPC_LD));
    issue(enc_i(12'hfff, 5'd10, 3'd0, 5'd6, OPC_LD));
    issue(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd6));
    // failed load keeps rd
    issue(enc_i(12'd77, 5'd0, 3'd0, 5'd12, OPC_OPI));
    issue(enc_u(20'hF0000, 5'd11));
    issue(enc_i(12'h008, 5'd11, 3'd2, 5'd12, OPC_LD));
    issue(enc_r(7'h00, 5'd0, 5'd12, 3'd0, 5'd13));
    // unknown opcode, bad funct7, ld
    issue(32'hFFFF_FFFF);
    issue(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd7));
    issue(enc_i(12'h000, 5'd10, 3'd3, 5'd7, OPC_LD));
    issue(enc_i(12'h001, 5'd7, 3'd0, 5'd7, OPC_OPI));
    // x0 as destination and source
    issue(enc_i(12'h005, 5'd1, 3'd0, 5'd0, OPC_OPI));
    issue(enc_u(20'hABCDE, 5'd0));
    issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd14));
    repeat (N_RAND) issue_random();
    instr_valid_i = 1'b0;
    while (q_kind.size() != 0) @(negedge clk);
    repeat (5) @(negedge clk);
    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // run limit scales with the number of instructions
  initial begin
    #(N_INSTR * 40 * CLK_PERIOD);
    $display("watchdog expired with %0d results still outstanding", q_kind.size());
    $display("test failed");
    $finish;
  end

endmodule

/* hw/rv_core_lite.sv */
`timescale 1ns/1ps

module rv_core_lite
  import rv_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  instr_valid_i,
  input  logic [XLEN-1:0]       instr_i,
  output logic                  instr_ready_o,
  output logic [XLEN-1:0]       araddr_o,
  output logic [AXI_PROT_W-1:0] arprot_o,
  output logic                  arvalid_o,
  input  logic                  arready_i,
  input  logic [XLEN-1:0]       rdata_i,
  input  logic [AXI_RESP_W-1:0] rresp_i,
  input  logic                  rvalid_i,
  output logic                  rready_o,
  output logic                  wb_valid_o,
  output logic [REG_ADDR_W-1:0] wb_rd_o,
  output logic [XLEN-1:0]       wb_data_o,
  output logic                  illegal_o,
  output logic                  load_err_o
);

  // decode stage
  decoded_instr_t dec_in;
  decoded_instr_t dec_out;
  logic           dec_valid;
  logic           dec_ready;

  // result stage
  exec_result_t res_in;
  exec_result_t res_out;
  logic         res_in_valid;
  logic         res_valid;
  logic         res_ready;

  rv_rf_if rf_if ();

  rv_id u_id (
    .instr_i (instr_i),
    .decode_o(dec_in)
  );

  rv_stage_buf #(
    .payload_t(decoded_instr_t)
  ) u_dec_buf (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .in_valid_i   (instr_valid_i),
    .in_payload_i (dec_in),
    .in_ready_o   (instr_ready_o),
    .out_valid_o  (dec_valid),
    .out_payload_o(dec_out),
    .out_ready_i  (dec_ready)
  );

  rv_exec u_exec (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .in_valid_i   (dec_valid),
    .in_payload_i (dec_out),
    .in_ready_o   (dec_ready),
    .res_valid_o  (res_in_valid),
    .res_payload_o(res_in),
    .illegal_o    (illegal_o),
    .rf           (rf_if.requester),
    .araddr_o     (araddr_o),
    .arprot_o     (arprot_o),
    .arvalid_o    (arvalid_o),
    .arready_i    (arready_i),
    .rdata_i      (rdata_i),
    .rresp_i      (rresp_i),
    .rvalid_i     (rvalid_i),
    .rready_o     (rready_o)
  );

  // result side never stalls, its input ready stays open
  rv_stage_buf #(
    .payload_t(exec_result_t)
  ) u_res_buf (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .in_valid_i   (res_in_valid),
    .in_payload_i (res_in),
    .in_ready_o   (),
    .out_valid_o  (res_valid),
    .out_payload_o(res_out),
    .out_ready_i  (res_ready)
  );

  rv_result u_result (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (res_valid),
    .in_payload_i(res_out),
    .in_ready_o  (res_ready),
    .rf          (rf_if.responder),
    .wb_valid_o  (wb_valid_o),
    .wb_rd_o     (wb_rd_o),
    .wb_data_o   (wb_data_o),
    .load_err_o  (load_err_o)
  );

endmodule

/* hw/rv_exec.sv */
`timescale 1ns/1ps

module rv_exec
  import rv_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  in_valid_i,
  input  decoded_instr_t        in_payload_i,
  output logic                  in_ready_o,
  output logic                  res_valid_o,
  output exec_result_t          res_payload_o,
  output logic                  illegal_o,
  rv_rf_if.requester            rf,
  output logic [XLEN-1:0]       araddr_o,
  output logic [AXI_PROT_W-1:0] arprot_o,
  output logic                  arvalid_o,
  input  logic                  arready_i,
  input  logic [XLEN-1:0]       rdata_i,
  input  logic [AXI_RESP_W-1:0] rresp_i,
  input  logic                  rvalid_i,
  output logic                  rready_o
);

  // load sequencing
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_AR,
    ST_R
  } ld_state_t;

  ld_state_t       state_q;
  ld_state_t       state_d;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] alu_out;
  logic [XLEN-1:0] addr_q;
  logic [XLEN-1:0] ar_addr;
  logic            is_load;
  logic            start_load;
  logic            illegal_q;

  //////////////////////////////////////////////////
  // operands and alu
  //////////////////////////////////////////////////

  assign rf.rs1_addr = in_payload_i.rs1;
  assign rf.rs2_addr = in_payload_i.rs2;

  assign op_a = rf.rs1_data;
  assign op_b = in_payload_i.use_imm ? in_payload_i.imm : rf.rs2_data;
  // shared by add and load address
  assign sum  = op_a + op_b;

  always_comb begin
    case (in_payload_i.func)
      ADD:     alu_out = sum;
      SUB:     alu_out = op_a - op_b;
      AND:     alu_out = op_a & op_b;
      OR:      alu_out = op_a | op_b;
      XOR:     alu_out = op_a ^ op_b;
      SLT:     alu_out = {{(XLEN - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
      SLTU:    alu_out = {{(XLEN - 1){1'b0}}, op_a < op_b};
      SLL:     alu_out = op_a << op_b[SHAMT_W-1:0];
      SRL:     alu_out = op_a >> op_b[SHAMT_W-1:0];
      SRA:     alu_out = $unsigned($signed(op_a) >>> op_b[SHAMT_W-1:0]);
      // lui immediate is already shifted
      LUI:     alu_out = op_b;
      default: alu_out = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // axi4-lite read master
  //////////////////////////////////////////////////

  assign is_load    = in_payload_i.func inside {LB, LH, LW, LBU, LHU};
  assign start_load = (state_q == ST_IDLE) && in_valid_i && is_load;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (start_load) state_d = arready_i ? ST_R : ST_AR;
      ST_AR:   if (arready_i) state_d = ST_R;
      ST_R:    if (rvalid_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  // first request cycle uses the live sum, later ones the copy
  assign ar_addr   = (state_q == ST_IDLE) ? sum : addr_q;
  assign araddr_o  = {ar_addr[XLEN-1:2], 2'b00};
  assign arprot_o  = AXI_ARPROT;
  assign arvalid_o = start_load || (state_q == ST_AR);
  assign rready_o  = (state_q == ST_R);

  // loads hold the decode buffer until the r beat
  assign in_ready_o = ((state_q == ST_IDLE) && !is_load) || ((state_q == ST_R) && rvalid_i);

  // illegal is consumed without a result
  assign res_valid_o = ((state_q == ST_IDLE) && in_valid_i && !is_load &&
                        (in_payload_i.func != ILLEGAL)) ||
                       ((state_q == ST_R) && rvalid_i);

  always_comb begin
    res_payload_o.rd      = in_payload_i.rd;
    res_payload_o.we      = (in_payload_i.rd != '0);
    res_payload_o.value   = (state_q == ST_R) ? rdata_i : alu_out;
    res_payload_o.func    = in_payload_i.func;
    // byte lane for the extraction in result
    res_payload_o.addr_lo = addr_q[1:0];
    res_payload_o.err     = (state_q == ST_R) && (rresp_i != AXI_RESP_OKAY);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= ST_IDLE;
      illegal_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      // lines up with writeback of other instructions
      illegal_q <= (state_q == ST_IDLE) && in_valid_i && (in_payload_i.func == ILLEGAL);
    end
  end

  assign illegal_o = illegal_q;

  // full address kept for the whole load
  always_ff @(posedge clk_i) begin
    if (start_load) begin
      addr_q <= sum;
    end
  end

  a_ar_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o));

  a_no_r_during_ar: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(rready_o && arvalid_o));

endmodule

/* hw/rv_id.sv */
`timescale 1ns/1ps

module rv_id
  import rv_pkg::*;
(
  input  logic [XLEN-1:0] instr_i,
  output decoded_instr_t  decode_o
);

  //////////////////////////////////////////////////
  // fields
  //////////////////////////////////////////////////

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // i-type, sign extended from bit 31
  assign imm_i = {{(XLEN - 12){instr_i[31]}}, instr_i[31:20]};
  // u-type, low 12 bits clear
  assign imm_u = {instr_i[31:12], 12'b0};

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////

  always_comb begin
    decode_o = '0;
    case (opcode)
      OPC_LOAD: begin
        decode_o.rd      = instr_i[11:7];
        decode_o.rs1     = instr_i[19:15];
        decode_o.imm     = imm_i;
        decode_o.use_imm = 1'b1;
        // ld and lwu are rv64 only, left as illegal
        case (funct3)
          3'd0:    decode_o.func = LB;
          3'd1:    decode_o.func = LH;
          3'd2:    decode_o.func = LW;
          3'd4:    decode_o.func = LBU;
          3'd5:    decode_o.func = LHU;
          default: decode_o.func = ILLEGAL;
        endcase
      end
      OPC_OP_IMM: begin
        decode_o.rd      = instr_i[11:7];
        decode_o.rs1     = instr_i[19:15];
        decode_o.imm     = imm_i;
        decode_o.use_imm = 1'b1;
        case (funct3)
          3'd0: decode_o.func = ADD;
          3'd2: decode_o.func = SLT;
          3'd3: decode_o.func = SLTU;
          3'd4: decode_o.func = XOR;
          3'd6: decode_o.func = OR;
          3'd7: decode_o.func = AND;
          // shamt sits in imm[4:0], funct7 still checked
          3'd1: decode_o.func = (funct7 == FUNCT7_BASE) ? SLL : ILLEGAL;
          3'd5: begin
            if (funct7 == FUNCT7_BASE) begin
              decode_o.func = SRL;
            end else if (funct7 == FUNCT7_ALT) begin
              decode_o.func = SRA;
            end
          end
          default: decode_o.func = ILLEGAL;
        endcase
      end
      OPC_OP: begin
        decode_o.rd  = instr_i[11:7];
        decode_o.rs1 = instr_i[19:15];
        decode_o.rs2 = instr_i[24:20];
        if (funct7 == FUNCT7_BASE) begin
          case (funct3)
            3'd0: decode_o.func = ADD;
            3'd1: decode_o.func = SLL;
            3'd2: decode_o.func = SLT;
            3'd3: decode_o.func = SLTU;
            3'd4: decode_o.func = XOR;
            3'd5: decode_o.func = SRL;
            3'd6: decode_o.func = OR;
            3'd7: decode_o.func = AND;
            default: decode_o.func = ILLEGAL;
          endcase
        end else if (funct7 == FUNCT7_ALT) begin
          // alt form only for sub and sra
          case (funct3)
            3'd0:    decode_o.func = SUB;
            3'd5:    decode_o.func = SRA;
            default: decode_o.func = ILLEGAL;
          endcase
        end
      end
      OPC_LUI: begin
        decode_o.rd      = instr_i[11:7];
        decode_o.imm     = imm_u;
        decode_o.use_imm = 1'b1;
        decode_o.func    = LUI;
      end
      default: begin
        decode_o.func = ILLEGAL;
      end
    endcase
    // illegal carries no operands downstream
    if (decode_o.func == ILLEGAL) begin
      decode_o = '0;
    end
  end

  // known encoding in, fully known decode out
  always_comb begin
    if (!$isunknown(instr_i)) begin
      a_decode_known: assert final (!$isunknown(decode_o));
    end
  end

endmodule

/* hw/rv_pkg.sv */
package rv_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // integer datapath width, RV32I only
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 2 ** REG_ADDR_W;
  // shift amounts use the low bits only
  localparam int SHAMT_W    = $clog2(XLEN);

  // axi4-lite read side
  localparam int AXI_RESP_W = 2;
  localparam int AXI_PROT_W = 3;
  localparam logic [AXI_RESP_W-1:0] AXI_RESP_OKAY = 2'b00;
  // data access, secure, unprivileged
  localparam logic [AXI_PROT_W-1:0] AXI_ARPROT = 3'b000;

  // major opcodes handled by the slice
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct7 patterns
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

  //////////////////////////////////////////////////
  // payload types
  //////////////////////////////////////////////////

  // illegal must stay the zero encoding
  typedef enum logic [4:0] {
    ILLEGAL = 5'd0,
    LB, LH, LW, LBU, LHU,
    ADD, SUB, AND, OR, XOR,
    SLT, SLTU, SLL, SRL, SRA,
    LUI
  } func_t;

  // decoder output, held in the decode buffer
  typedef struct packed {
    func_t                 func;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm;
    logic                  use_imm;
  } decoded_instr_t;

  // execute to result, held in the result buffer
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic                  we;
    logic [XLEN-1:0]       value;
    func_t                 func;
    logic [1:0]            addr_lo;
    logic                  err;
  } exec_result_t;

endpackage

/* hw/rv_result.sv */
`timescale 1ns/1ps

module rv_result
  import rv_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  in_valid_i,
  input  exec_result_t          in_payload_i,
  output logic                  in_ready_o,
  rv_rf_if.responder            rf,
  output logic                  wb_valid_o,
  output logic [REG_ADDR_W-1:0] wb_rd_o,
  output logic [XLEN-1:0]       wb_data_o,
  output logic                  load_err_o
);

  logic [XLEN-1:0] regs_q [NUM_REGS];
  logic [7:0]      ld_byte;
  logic [15:0]     ld_half;
  logic [XLEN-1:0] ext_data;
  logic [XLEN-1:0] wb_data;
  logic            rf_we;

  // x0 is zero, pending write wins over the array
  function automatic logic [XLEN-1:0] rd_port(input logic [REG_ADDR_W-1:0] addr);
    if (addr == '0) begin
      return '0;
    end
    if (rf_we && (addr == in_payload_i.rd)) begin
      return wb_data;
    end
    return regs_q[addr];
  endfunction

  //////////////////////////////////////////////////
  // load extraction
  //////////////////////////////////////////////////

  always_comb begin
    case (in_payload_i.addr_lo)
      2'd0:    ld_byte = in_payload_i.value[7:0];
      2'd1:    ld_byte = in_payload_i.value[15:8];
      2'd2:    ld_byte = in_payload_i.value[23:16];
      default: ld_byte = in_payload_i.value[31:24];
    endcase
  end

  // halfword lane from bit 1 only
  assign ld_half = in_payload_i.addr_lo[1] ? in_payload_i.value[31:16] :
                                             in_payload_i.value[15:0];

  always_comb begin
    case (in_payload_i.func)
      LB:      ext_data = {{(XLEN - 8){ld_byte[7]}}, ld_byte};
      LBU:     ext_data = {{(XLEN - 8){1'b0}}, ld_byte};
      LH:      ext_data = {{(XLEN - 16){ld_half[15]}}, ld_half};
      LHU:     ext_data = {{(XLEN - 16){1'b0}}, ld_half};
      // lw and alu results pass through
      default: ext_data = in_payload_i.value;
    endcase
  end

  //////////////////////////////////////////////////
  // writeback and register file
  //////////////////////////////////////////////////

  // rd of x0 shows up with zero data
  assign wb_data = in_payload_i.we ? ext_data : '0;
  assign rf_we   = in_valid_i && in_payload_i.we && !in_payload_i.err;

  assign in_ready_o = 1'b1;
  assign wb_valid_o = in_valid_i && !in_payload_i.err;
  assign wb_rd_o    = in_payload_i.rd;
  assign wb_data_o  = wb_data;
  assign load_err_o = in_valid_i && in_payload_i.err;

  always_comb begin
    rf.rs1_data = rd_port(rf.rs1_addr);
    rf.rs2_data = rd_port(rf.rs2_addr);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      regs_q <= '{default: '0};
    end else if (rf_we) begin
      regs_q[in_payload_i.rd] <= wb_data;
    end
  end

endmodule

/* hw/rv_rf_if.sv */
`timescale 1ns/1ps

interface rv_rf_if
  import rv_pkg::*;
();

  // two read ports, answered in the same cycle
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;

  // execute side
  modport requester(output rs1_addr, output rs2_addr, input rs1_data, input rs2_data);

  // register file side
  modport responder(input rs1_addr, input rs2_addr, output rs1_data, output rs2_data);

endinterface

/* hw/rv_stage_buf.sv */
`timescale 1ns/1ps

module rv_stage_buf #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     in_valid_i,
  input  payload_t in_payload_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output payload_t out_payload_o,
  input  logic     out_ready_i
);

  logic     full_q;
  payload_t payload_q;

  // room when empty or when the head leaves this cycle
  assign in_ready_o    = !full_q || out_ready_i;
  assign out_valid_o   = full_q;
  assign out_payload_o = payload_q;

  // occupancy
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      full_q <= 1'b1;
    end else if (out_ready_i) begin
      full_q <= 1'b0;
    end
  end

  // data only moves on an accepted input
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      payload_q <= in_payload_i;
    end
  end

  // a stalled head must not change under the consumer
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i |=> $stable(payload_q));

endmodule

/* rv_core_lite.f */
hw/rv_pkg.sv
hw/rv_rf_if.sv
hw/rv_stage_buf.sv
hw/rv_id.sv
hw/rv_exec.sv
hw/rv_result.sv
hw/rv_core_lite.sv
dv/rv_clk_gen.sv
dv/rv_core_lite_tb.sv
